// File: procPkg.sv
// Shared word types, opcode encodings and memory sizes, referenced by scoped name from every stage
package procPkg;

    typedef logic [15:0] word_t;     // Data and instruction word
    typedef logic [2:0]  regAddr_t;  // Register index
    typedef logic [7:0]  pc_t;       // Word address into either memory
    typedef logic [3:0]  opcode_t;   // Instruction bits 15:12

    // Instruction fields
    //   rd 11:9, rs 8:6, rt 5:3, imm6 5:0, imm8 7:0, imm12 11:0
    //   ST stores rd, BEQZ and BNEZ test rd
    localparam opcode_t OP_NOP  = 4'h0;
    localparam opcode_t OP_ADD  = 4'h1;  // rd = rs + rt
    localparam opcode_t OP_SUB  = 4'h2;  // rd = rs - rt
    localparam opcode_t OP_AND  = 4'h3;
    localparam opcode_t OP_XOR  = 4'h4;
    localparam opcode_t OP_ADDI = 4'h5;  // rd = rs + sext(imm6)
    localparam opcode_t OP_LBI  = 4'h6;  // rd = sext(imm8)
    localparam opcode_t OP_LD   = 4'h7;  // rd = mem[rs + sext(imm6)]
    localparam opcode_t OP_ST   = 4'h8;  // mem[rs + sext(imm6)] = rd
    localparam opcode_t OP_BEQZ = 4'h9;  // pc + 1 + sext(imm8) if rd == 0
    localparam opcode_t OP_BNEZ = 4'hA;  // pc + 1 + sext(imm8) if rd != 0
    localparam opcode_t OP_J    = 4'hB;  // pc + 1 + sext(imm12)
    localparam opcode_t OP_HALT = 4'hF;

    localparam int IMEM_DEPTH = 256;  // Instruction ROM words
    localparam int DMEM_DEPTH = 256;  // Data RAM words
    localparam int NUM_REGS   = 8;

endpackage

// File: stageBus.sv
// One instruction's state between two pipeline stages; the upstream stage drives src, the next reads sink
interface stageBus;

    logic               valid;
    procPkg::pc_t       pc;
    procPkg::word_t     instr;
    procPkg::word_t     opA;       // First register operand
    procPkg::word_t     opB;       // Second operand or store data
    procPkg::word_t     result;    // ALU result or memory address
    procPkg::regAddr_t  destReg;
    logic               regWrite;

    modport src (
        output valid, pc, instr, opA, opB, result, destReg, regWrite
    );

    modport sink (
        input valid, pc, instr, opA, opB, result, destReg, regWrite
    );

endinterface

// File: fetch.sv
// Fetch stage with the PC, the instruction ROM loaded from prog.hex and the IF/ID register
module fetch (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,     // Hold PC and IF/ID
    input  logic          redirect,  // Taken branch or jump in execute
    input  procPkg::pc_t  target,
    input  logic          halted,
    stageBus.src          out
);

    procPkg::word_t rom [procPkg::IMEM_DEPTH];

    procPkg::pc_t   pc;
    procPkg::pc_t   idPc;      // IF/ID payload
    procPkg::word_t idInstr;
    logic           idValid;

    initial begin
        $readmemh("prog.hex", rom);
    end

    // Control state, redirect wins over stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            idValid <= 1'b0;
        end else if (redirect) begin
            pc      <= target;
            idValid <= 1'b0;  // Drop the wrong-path fetch
        end else if (!stall) begin
            pc      <= pc + 8'd1;
            idValid <= !halted;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !redirect) begin
            idPc    <= pc;
            idInstr <= rom[pc];
        end
    end

    assign out.valid    = idValid;
    assign out.pc       = idPc;
    assign out.instr    = idInstr;
    assign out.opA      = '0;  // Filled in by decode
    assign out.opB      = '0;
    assign out.result   = '0;
    assign out.destReg  = '0;
    assign out.regWrite = 1'b0;

endmodule

// File: decode.sv
// Decode stage with the register file, hazard stall logic and the ID/EX register
module decode (
    input  logic               clk,
    input  logic               rstN,
    stageBus.sink              in,
    stageBus.src               out,
    input  logic               redirect,  // Flush the instruction moving into ID/EX
    input  logic               wbEn,
    input  procPkg::regAddr_t  wbAddr,
    input  procPkg::word_t     wbData,
    stageBus.sink              exDest,    // EX/MEM, checked for pending writes
    output logic               stall
);

    procPkg::word_t regs [procPkg::NUM_REGS];

    procPkg::opcode_t  op;
    procPkg::regAddr_t srcA, srcB, destReg;
    logic              useA, useB, regWrite;
    procPkg::word_t    rdA, rdB;
    logic              hazA, hazB, isHalt, issue;
    logic              haltSent;  // HALT already passed into ID/EX

    // ID/EX register
    logic              exValid;
    logic              exRegWrite;
    procPkg::regAddr_t exDestReg;
    procPkg::pc_t      exPc;
    procPkg::word_t    exInstr, exOpA, exOpB;

    assign op = in.instr[15:12];

    always_comb begin
        srcA     = in.instr[8:6];   // rs
        srcB     = in.instr[5:3];   // rt
        destReg  = in.instr[11:9];  // rd
        useA     = 1'b0;
        useB     = 1'b0;
        regWrite = 1'b0;
        case (op)
            procPkg::OP_ADD, procPkg::OP_SUB, procPkg::OP_AND, procPkg::OP_XOR: begin
                useA     = 1'b1;
                useB     = 1'b1;
                regWrite = 1'b1;
            end
            procPkg::OP_ADDI, procPkg::OP_LD: begin
                useA     = 1'b1;
                regWrite = 1'b1;
            end
            procPkg::OP_LBI: regWrite = 1'b1;
            procPkg::OP_ST: begin
                useA = 1'b1;
                useB = 1'b1;
                srcB = in.instr[11:9];  // Store data comes from rd
            end
            procPkg::OP_BEQZ, procPkg::OP_BNEZ: begin
                useA = 1'b1;
                srcA = in.instr[11:9];  // Tested register
            end
            procPkg::OP_NOP, procPkg::OP_J, procPkg::OP_HALT: ;
            default: ;  // Unused encodings behave as NOP
        endcase
    end

    // Write-through so a writeback this cycle is seen by the read
    assign rdA = (wbEn && wbAddr == srcA) ? wbData : regs[srcA];
    assign rdB = (wbEn && wbAddr == srcB) ? wbData : regs[srcB];

    // Pending writers in ID/EX and EX/MEM; MEM/WB is covered by write-through
    assign hazA = useA && ((exValid && exRegWrite && exDestReg == srcA) ||
                           (exDest.valid && exDest.regWrite && exDest.destReg == srcA));
    assign hazB = useB && ((exValid && exRegWrite && exDestReg == srcB) ||
                           (exDest.valid && exDest.regWrite && exDest.destReg == srcB));

    assign isHalt = (op == procPkg::OP_HALT);
    assign stall  = in.valid && (hazA || hazB || isHalt);  // HALT freezes fetch for good
    assign issue  = in.valid && !hazA && !hazB && !haltSent;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < procPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid  <= 1'b0;
            haltSent <= 1'b0;
        end else begin
            exValid <= issue && !redirect;  // Bubble on stall or flush
            if (issue && !redirect && isHalt) begin
                haltSent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        exPc       <= in.pc;
        exInstr    <= in.instr;
        exOpA      <= rdA;
        exOpB      <= rdB;
        exDestReg  <= destReg;
        exRegWrite <= regWrite;
    end

    assign out.valid    = exValid;
    assign out.pc       = exPc;
    assign out.instr    = exInstr;
    assign out.opA      = exOpA;
    assign out.opB      = exOpB;
    assign out.result   = '0;  // Produced in execute
    assign out.destReg  = exDestReg;
    assign out.regWrite = exRegWrite;

endmodule

// File: execute.sv
// Execute stage with the ALU, branch and jump resolution and the EX/MEM register
module execute (
    input  logic          clk,
    input  logic          rstN,
    stageBus.sink         in,
    stageBus.src          out,
    output logic          redirect,  // One-cycle pulse on a taken branch or jump
    output procPkg::pc_t  target
);

    procPkg::opcode_t op;
    procPkg::word_t   imm6, imm8, result;
    logic             taken;

    // EX/MEM register
    logic              memValid;
    logic              memRegWrite;
    procPkg::regAddr_t memDestReg;
    procPkg::pc_t      memPc;
    procPkg::word_t    memInstr, memOpA, memOpB, memResult;

    assign op   = in.instr[15:12];
    assign imm6 = {{10{in.instr[5]}}, in.instr[5:0]};
    assign imm8 = {{8{in.instr[7]}}, in.instr[7:0]};

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (op)
            procPkg::OP_ADD:  result = in.opA + in.opB;
            procPkg::OP_SUB:  result = in.opA - in.opB;
            procPkg::OP_AND:  result = in.opA & in.opB;
            procPkg::OP_XOR:  result = in.opA ^ in.opB;
            procPkg::OP_ADDI, procPkg::OP_LD, procPkg::OP_ST:
                result = in.opA + imm6;  // Memory uses the low byte as address
            procPkg::OP_LBI:  result = imm8;
            procPkg::OP_BEQZ: taken = (in.opA == '0);
            procPkg::OP_BNEZ: taken = (in.opA != '0);
            procPkg::OP_J:    taken = 1'b1;
            default: ;
        endcase
    end

    // Targets wrap at 256, so only the low offset byte matters for imm8 and imm12 alike
    assign target   = in.pc + 8'd1 + in.instr[7:0];
    assign redirect = in.valid && taken;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memValid <= 1'b0;
        end else begin
            memValid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        memPc       <= in.pc;
        memInstr    <= in.instr;
        memOpA      <= in.opA;
        memOpB      <= in.opB;  // Store data rides along
        memResult   <= result;
        memDestReg  <= in.destReg;
        memRegWrite <= in.regWrite;
    end

    assign out.valid    = memValid;
    assign out.pc       = memPc;
    assign out.instr    = memInstr;
    assign out.opA      = memOpA;
    assign out.opB      = memOpB;
    assign out.result   = memResult;
    assign out.destReg  = memDestReg;
    assign out.regWrite = memRegWrite;

endmodule

// File: memory.sv
// Memory stage with the data RAM and the MEM/WB register that drives register writeback and halt
module memory (
    input  logic               clk,
    input  logic               rstN,
    stageBus.sink              in,
    output logic               wbEn,
    output procPkg::regAddr_t  wbAddr,
    output procPkg::word_t     wbData,
    output logic               memWe,
    output procPkg::pc_t       memAddr,
    output procPkg::word_t     memWrData,
    output logic               halted   // Sticky once HALT retires
);

    procPkg::word_t   ram [procPkg::DMEM_DEPTH];
    procPkg::opcode_t op;
    logic             wbHalt;  // HALT sitting in MEM/WB

    assign op        = in.instr[15:12];
    assign memWe     = in.valid && op == procPkg::OP_ST;
    assign memAddr   = in.result[7:0];
    assign memWrData = in.opB;

    always_ff @(posedge clk) begin
        if (memWe) begin
            ram[memAddr] <= memWrData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbEn   <= 1'b0;
            wbHalt <= 1'b0;
            halted <= 1'b0;
        end else begin
            wbEn   <= in.valid && in.regWrite;
            wbHalt <= in.valid && op == procPkg::OP_HALT;
            if (wbHalt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= in.destReg;
        wbData <= (op == procPkg::OP_LD) ? ram[memAddr] : in.result;  // Load data or ALU
    end

endmodule

// File: proc.sv
// Top level of the five-stage pipeline, wiring the stages together and exposing writeback and store ports
module proc (
    input  logic               clk,
    input  logic               rstN,
    output logic               halted,
    output logic               wbEn,
    output procPkg::regAddr_t  wbAddr,
    output procPkg::word_t     wbData,
    output logic               memWe,
    output procPkg::pc_t       memAddr,
    output procPkg::word_t     memWrData
);

    stageBus ifId ();   // Fetch to decode
    stageBus idEx ();   // Decode to execute
    stageBus exMem ();  // Execute to memory

    logic         stall;
    logic         redirect;
    procPkg::pc_t target;

    fetch iFetch (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .halted   (halted),
        .out      (ifId.src)
    );

    decode iDecode (
        .clk      (clk),
        .rstN     (rstN),
        .in       (ifId.sink),
        .out      (idEx.src),
        .redirect (redirect),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .exDest   (exMem.sink),
        .stall    (stall)
    );

    execute iExecute (
        .clk      (clk),
        .rstN     (rstN),
        .in       (idEx.sink),
        .out      (exMem.src),
        .redirect (redirect),
        .target   (target)
    );

    memory iMemory (
        .clk       (clk),
        .rstN      (rstN),
        .in        (exMem.sink),
        .wbEn      (wbEn),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .memWe     (memWe),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .halted    (halted)
    );

endmodule

// File: procTb.sv
// Testbench for proc, runs prog.hex on an instruction-set model and compares every write and store
module procTb;

    logic              clk;
    logic              rstN;
    logic              halted;
    logic              wbEn;
    procPkg::regAddr_t wbAddr;
    procPkg::word_t    wbData;
    logic              memWe;
    procPkg::pc_t      memAddr;
    procPkg::word_t    memWrData;

    procPkg::word_t    refImem [procPkg::IMEM_DEPTH];  // Reference model state
    procPkg::word_t    refDmem [procPkg::DMEM_DEPTH];
    procPkg::word_t    refRegs [procPkg::NUM_REGS];
    logic              refOk;

    procPkg::regAddr_t expWrAddr [$];
    procPkg::word_t    expWrData [$];
    logic [2:0]        expWrTest [$];  // Test number of each expected write
    procPkg::pc_t      expStAddr [$];
    procPkg::word_t    expStData [$];

    int checkCount [8];  // Indexed by test number 1 to 5
    int errCount   [8];
    int seenWrites;      // Register writes and stores seen so far

    proc i_proc (
        .clk       (clk),
        .rstN      (rstN),
        .halted    (halted),
        .wbEn      (wbEn),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .memWe     (memWe),
        .memAddr   (memAddr),
        .memWrData (memWrData)
    );

    always #50 clk = ~clk;

    function string testName(input logic [2:0] testId);
        case (testId)
            3'd1:    return "ALU and immediate writes";
            3'd2:    return "stores and loads";
            3'd3:    return "branches, jumps and flushes";
            3'd4:    return "dependent instructions";
            default: return "halt and drain";
        endcase
    endfunction

    task automatic checkEq(input logic [2:0] testId, input logic [15:0] got,
                           input logic [15:0] expected, input string what);
        checkCount[testId]++;
        if (got !== expected) begin
            errCount[testId]++;
            $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, what, got, expected);
        end
    endtask

    task automatic reportTest(input logic [2:0] testId);
        $display("Test %0d %s: %0d checks, %0d errors", testId, testName(testId),
                 checkCount[testId], errCount[testId]);
    endtask

    function logic writtenRecently(input procPkg::regAddr_t r, input logic w1,
                                   input procPkg::regAddr_t d1, input logic w2,
                                   input procPkg::regAddr_t d2);
        return (w1 && d1 == r) || (w2 && d2 == r);
    endfunction

    // Instruction-set model, fills the expected write and store streams
    function void refRun();
        procPkg::pc_t      pc;
        procPkg::pc_t      nextPc;
        procPkg::pc_t      addr;
        procPkg::word_t    instr;
        procPkg::word_t    sum;
        procPkg::word_t    value;
        procPkg::word_t    target;
        procPkg::opcode_t  op;
        procPkg::regAddr_t rd, rs, rt;
        procPkg::regAddr_t prev1Dest, prev2Dest;
        logic              prev1Write, prev2Write;
        logic              writes, isMem, useRs, useRt, useRd, dep, branched, done;
        int                steps;

        $readmemh("prog.hex", refImem);
        refRegs    = '{default: '0};
        pc         = '0;
        prev1Dest  = '0;
        prev2Dest  = '0;
        prev1Write = 1'b0;
        prev2Write = 1'b0;
        branched   = 1'b0;
        done       = 1'b0;
        steps      = 0;
        while (!done && steps < 10000) begin
            instr  = refImem[pc];
            op     = instr[15:12];
            rd     = instr[11:9];
            rs     = instr[8:6];
            rt     = instr[5:3];
            sum    = refRegs[rs] + {{10{instr[5]}}, instr[5:0]};  // Base plus imm6
            addr   = sum[7:0];
            nextPc = pc + 8'd1;
            value  = '0;
            writes = op inside {procPkg::OP_ADD, procPkg::OP_SUB, procPkg::OP_AND,
                                procPkg::OP_XOR, procPkg::OP_ADDI, procPkg::OP_LBI,
                                procPkg::OP_LD};
            useRt  = op inside {procPkg::OP_ADD, procPkg::OP_SUB, procPkg::OP_AND,
                                procPkg::OP_XOR};
            useRs  = useRt || (op inside {procPkg::OP_ADDI, procPkg::OP_LD, procPkg::OP_ST});
            useRd  = op inside {procPkg::OP_ST, procPkg::OP_BEQZ, procPkg::OP_BNEZ};
            isMem  = op inside {procPkg::OP_LD, procPkg::OP_ST};
            case (op)
                procPkg::OP_ADD:  value = refRegs[rs] + refRegs[rt];
                procPkg::OP_SUB:  value = refRegs[rs] - refRegs[rt];
                procPkg::OP_AND:  value = refRegs[rs] & refRegs[rt];
                procPkg::OP_XOR:  value = refRegs[rs] ^ refRegs[rt];
                procPkg::OP_ADDI: value = sum;
                procPkg::OP_LBI:  value = {{8{instr[7]}}, instr[7:0]};
                procPkg::OP_LD:   value = refDmem[addr];
                procPkg::OP_ST: begin
                    refDmem[addr] = refRegs[rd];
                    expStAddr.push_back(addr);
                    expStData.push_back(refRegs[rd]);
                end
                procPkg::OP_BEQZ, procPkg::OP_BNEZ: begin
                    branched = 1'b1;
                    if ((refRegs[rd] == '0) == (op == procPkg::OP_BEQZ)) begin
                        target = {8'd0, pc} + 16'd1 + {{8{instr[7]}}, instr[7:0]};
                        nextPc = target[7:0];  // Wraps at 256
                    end
                end
                procPkg::OP_J: begin
                    branched = 1'b1;
                    target   = {8'd0, pc} + 16'd1 + {{4{instr[11]}}, instr[11:0]};
                    nextPc   = target[7:0];
                end
                procPkg::OP_HALT: done = 1'b1;
                default: ;  // NOP
            endcase
            // Reads of the last two results are the ones the pipeline must stall on
            dep = (useRs && writtenRecently(rs, prev1Write, prev1Dest, prev2Write, prev2Dest)) ||
                  (useRt && writtenRecently(rt, prev1Write, prev1Dest, prev2Write, prev2Dest)) ||
                  (useRd && writtenRecently(rd, prev1Write, prev1Dest, prev2Write, prev2Dest));
            if (writes) begin
                refRegs[rd] = value;
                expWrAddr.push_back(rd);
                expWrData.push_back(value);
                expWrTest.push_back(isMem ? 3'd2 : dep ? 3'd4 : branched ? 3'd3 : 3'd1);
            end
            prev2Dest  = prev1Dest;
            prev2Write = prev1Write;
            prev1Dest  = rd;
            prev1Write = writes;
            pc         = nextPc;
            steps++;
        end
        refOk = done;
        if (!done) begin
            $display("Reference model did not reach HALT within 10000 instructions");
        end
    endfunction

    always @(posedge clk) begin : compareStreams
        procPkg::regAddr_t expAddr;
        procPkg::pc_t      expSt;
        procPkg::word_t    expData;
        logic [2:0]        testId;

        if (rstN && wbEn) begin
            seenWrites++;
            if (expWrAddr.size() == 0) begin
                checkCount[3]++;
                errCount[3]++;  // Extra write, e.g. from a flushed instruction
                $display("Register r%0d was written at time %0t but no write was expected",
                         wbAddr, $time);
            end else begin
                expAddr = expWrAddr.pop_front();
                expData = expWrData.pop_front();
                testId  = expWrTest.pop_front();
                checkEq(testId, {13'd0, wbAddr}, {13'd0, expAddr}, "register write address");
                checkEq(testId, wbData, expData, "register write data");
            end
        end
        if (rstN && memWe) begin
            seenWrites++;
            if (expStAddr.size() == 0) begin
                checkCount[2]++;
                errCount[2]++;
                $display("A store to address %0d happened at time %0t but none was expected",
                         memAddr, $time);
            end else begin
                expSt   = expStAddr.pop_front();
                expData = expStData.pop_front();
                checkEq(3'd2, {8'd0, memAddr}, {8'd0, expSt}, "store address");
                checkEq(3'd2, memWrData, expData, "store data");
            end
        end
    end

    initial begin : mainFlow
        int waitCycles;
        int writesAtHalt;
        int totalChecks;
        int totalErrors;

        clk        = 1'b0;
        rstN       = 1'b0;
        seenWrites = 0;
        checkCount = '{default: 0};
        errCount   = '{default: 0};
        refRun();
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        waitCycles = 0;
        while (!halted && waitCycles < 1000) begin
            @(posedge clk);
            waitCycles++;
        end
        if (!halted) begin
            $display("Timeout: halted did not rise within 1000 cycles after reset");
            $display(">>> FAIL");
            $finish;
        end else begin
            @(negedge clk);
            checkCount[5]++;  // Halted rose in time
            checkEq(3'd5, 16'(expWrAddr.size()), 16'd0, "register writes left at halt");
            checkEq(3'd5, 16'(expStAddr.size()), 16'd0, "stores left at halt");
            for (int t = 1; t <= 4; t++) begin
                reportTest(t[2:0]);
            end
            writesAtHalt = seenWrites;
            repeat (20) @(posedge clk);
            @(negedge clk);
            checkEq(3'd5, 16'(seenWrites - writesAtHalt), 16'd0, "writes after halt");
            reportTest(3'd5);

            totalChecks = 0;
            totalErrors = refOk ? 0 : 1;
            for (int t = 1; t <= 5; t++) begin
                totalChecks += checkCount[t[2:0]];
                totalErrors += errCount[t[2:0]];
                if (checkCount[t[2:0]] == 0) begin
                    $display("Test %0d ran no checks", t);
                    totalErrors++;
                end
            end
            $display("Totals: %0d checks, %0d errors", totalChecks, totalErrors);
            if (totalErrors == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

// File: prog.hex
// One 16-bit instruction word per line in hex, starting at word address 0
// Columns: instruction word, then its assembly form
6205  // LBI  r1, 5
64FD  // LBI  r2, -3
0000  // NOP
0000  // NOP
1650  // ADD  r3, r1, r2
2850  // SUB  r4, r1, r2
3AE0  // AND  r5, r3, r4    back-to-back use of r4
4D08  // XOR  r6, r4, r1
5E7E  // ADDI r7, r1, -2
51DF  // ADDI r0, r7, 31
8604  // ST   r3, [r0 + 4]
8E3F  // ST   r7, [r0 - 1]
7204  // LD   r1, [r0 + 4]
1448  // ADD  r2, r1, r1    load followed by its use
7A3F  // LD   r5, [r0 - 1]
9A02  // BEQZ r5, +2        not taken
AA02  // BNEZ r5, +2        taken
6C77  // LBI  r6, 0x77      flushed
6E66  // LBI  r7, 0x66      flushed
2B68  // SUB  r5, r5, r5
9A01  // BEQZ r5, +1        taken
5241  // ADDI r1, r1, 1     flushed
B002  // J    +2
6611  // LBI  r3, 0x11      flushed
6822  // LBI  r4, 0x22      flushed
AA05  // BNEZ r5, +5        not taken
4680  // XOR  r3, r2, r0
8683  // ST   r3, [r2 + 3]  store data from the previous result
6803  // LBI  r4, 3         loop counter
5D82  // ADDI r6, r6, 2     loop body
593F  // ADDI r4, r4, -1
A8FD  // BNEZ r4, -3        back to the loop body
8C00  // ST   r6, [r0 + 0]
F000  // HALT
6255  // LBI  r1, 0x55      never issues

// File: vlog.f
procPkg.sv
stageBus.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc.sv
procTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary -f vlog.f --top-module procTb -o procTbSim
	@out="$$(./obj_dir/procTbSim)"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
